//--- vlog.f
design/blink_pkg.sv
design/blink_bus_if.sv
design/blink_mmu.sv
design/blink_rtc.sv
design/blink_int_ctrl.sv
design/blink_top.sv
testbench/blink_checker.sv
testbench/blink_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the blink testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module blink_tb -f vlog.f -o blink_sim \
  || { echo "Verilator build failed"; exit 1; }

out="$(./obj_dir/blink_sim)"
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx 'Simulation finished: PASS' \
  && echo "run.sh: test passed" \
  || { echo "run.sh: test failed"; exit 1; }

//--- testbench/blink_tb.sv
module blink_tb import blink_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int tb_div     = 16;                             // Short RTC ticks
  localparam int rtc_cycles = 61 * ticks_per_sec * tb_div;    // Past one minute
  localparam int n_steps    = 5;
  localparam longint wd_ns  = longint'(n_steps) * (rtc_cycles + 4096) * 20 + 10000;

  logic        mck;
  logic        rst_n;
  logic [15:0] ca;
  logic [7:0]  cdi;
  logic        crd_n;
  logic        mrq_n;
  logic        ior_n;
  logic        cm1_n;
  logic        hlt_n;
  logic [63:0] kbmat;
  logic [7:0]  cdo;
  logic [21:0] ma;
  logic        ipce_n;
  logic        irce_n;
  logic        se1_n;
  logic        se2_n;
  logic        se3_n;
  logic        roe_n;
  logic        wrb_n;
  logic        intb_n;
  logic        nmib_n;
  logic        pm1;
  logic        rout_n;

  int          errors = 0;
  int          checks = 0;
  int          cycle = 0;      // Rising mck edges so far
  int          pm1_edges = 0;
  logic [15:0] lfsr;
  seg_map_t    seg_model;      // Expected MMU state

  blink_top #(.tick_div(tb_div)) i_blink_top (
    .mck, .rst_n, .ca, .cdi, .crd_n, .mrq_n, .ior_n, .cm1_n, .hlt_n, .kbmat,
    .cdo, .ma, .ipce_n, .irce_n, .se1_n, .se2_n, .se3_n, .roe_n, .wrb_n,
    .intb_n, .nmib_n, .pm1, .rout_n
  );

  initial mck = 1'b0;
  always #10 mck = ~mck;  // 50 MHz

  always @(posedge mck) cycle <= cycle + 1;
  always @(posedge pm1) pm1_edges <= pm1_edges + 1;  // Z80 clock activity

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);  // One step per bit
      v = {v[62:0], lfsr[0]};
    end
  endtask

  // Physical address from the segment rules
  function automatic logic [21:0] exp_ma(input seg_map_t s, input logic [15:0] a);
    logic [7:0] low;
    low = s.rams ? rams_bank : 8'h00;
    case (a[15:14])
      2'b11: return {s.sr3, a[13:0]};
      2'b10: return {s.sr2, a[13:0]};
      2'b01: return {s.sr1, a[13:0]};
      default: return a[13] ? {s.sr0, 1'b1, a[12:0]} : {low, 1'b0, a[12:0]};
    endcase
  endfunction

  // {ipce_n, irce_n, se1_n, se2_n, se3_n, roe_n, wrb_n} during a memory cycle
  function automatic logic [6:0] exp_ce(input logic [21:0] m, input logic rd);
    logic [6:0] ce;
    ce[6] = ~(m[21:19] == prom_bank_hi);
    ce[5] = ~(m[21:19] == ram_bank_hi);
    ce[4] = ~(m[21:20] == 2'd1);
    ce[3] = ~(m[21:20] == 2'd2);
    ce[2] = ~(m[21:20] == 2'd3);
    ce[1] = ~rd;
    ce[0] = rd;
    return ce;
  endfunction

  // OR of the rows whose select bit is high
  function automatic logic [7:0] exp_kbd(input logic [63:0] km, input logic [7:0] rows);
    logic [7:0] k;
    k = 8'h00;
    for (int r = 0; r < 8; r++) begin
      if (rows[r]) begin
        k |= km[8*r +: 8];
      end
    end
    return k;
  endfunction

  // {tim4, tim3, tim2, tim1, tim0} after a number of ticks
  function automatic logic [39:0] exp_time(input int ticks);
    int mins;
    int secs;
    int t0;
    mins = ticks / (ticks_per_sec * secs_per_min);
    secs = (ticks / ticks_per_sec) % secs_per_min;
    t0   = ticks % ticks_per_sec;
    return {3'b000, mins[20:16], mins[15:8], mins[7:0], 2'b00, secs[5:0], t0[7:0]};
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge mck);
    #2;
  endtask

  task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
    ca    = addr;
    cdi   = data;
    crd_n = 1'b1;   // High means write
    ior_n = 1'b0;
    @(posedge mck);
    #2;
    ior_n = 1'b1;
    case (addr[7:0])
      port_sr0: seg_model.sr0 = data;
      port_sr1: seg_model.sr1 = data;
      port_sr2: seg_model.sr2 = data;
      port_sr3: seg_model.sr3 = data;
      port_com: seg_model.rams = data[2];
      default: ;
    endcase
  endtask

  // Byte is valid in the second cycle and cyc is the capture edge
  task automatic io_read(input logic [15:0] addr, output logic [7:0] data, output int cyc);
    ca    = addr;
    crd_n = 1'b0;
    ior_n = 1'b0;
    @(posedge mck);
    @(negedge mck);
    data = cdo;
    cyc  = cycle;
    @(posedge mck);
    #2;
    ior_n = 1'b1;
    crd_n = 1'b1;
    idle(1);        // Gap so the next read starts fresh
  endtask

  task automatic mem_access(input logic [15:0] addr, input logic rd);
    ca    = addr;
    crd_n = ~rd;
    mrq_n = 1'b0;   // Compare process looks at the negedge
    @(posedge mck);
    #2;
    mrq_n = 1'b1;
    crd_n = 1'b1;
  endtask

  task automatic int_ack();
    ior_n = 1'b0;
    cm1_n = 1'b0;
    @(posedge mck);
    #2;
    ior_n = 1'b1;
    cm1_n = 1'b1;
  endtask

  task automatic wait_intb_low(input int max_cyc, input string what);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < max_cyc && !seen; i++) begin
      @(negedge mck);
      seen = !intb_n;
    end
    if (!seen) begin
      errors++;
      $display("intb_n never went low while waiting for %s", what);
    end
    idle(1);
  endtask

  // Memory outputs against the mapping rules
  always @(negedge mck) begin
    if (rst_n && !mrq_n) begin
      check(ma, exp_ma(seg_model, ca), "ma");
      check({ipce_n, irce_n, se1_n, se2_n, se3_n, roe_n, wrb_n},
            exp_ce(exp_ma(seg_model, ca), ~crd_n), "chip enables and strobes");
    end
  end

  initial begin
    logic [63:0] r;
    logic [7:0]  d;
    logic [39:0] t;
    int          c;
    int          c0;
    int          e0;
    lfsr      = 16'd11874;
    seg_model = '0;
    rst_n     = 1'b0;
    ca        = 16'h0000;
    cdi       = 8'h00;
    crd_n     = 1'b1;
    mrq_n     = 1'b1;
    ior_n     = 1'b1;
    cm1_n     = 1'b1;
    hlt_n     = 1'b1;
    kbmat     = '0;
    repeat (8) @(posedge mck);
    #2;
    check(rout_n, 1'b0, "rout_n in reset");
    rst_n = 1'b1;
    idle(2);
    check({intb_n, nmib_n, rout_n}, 3'b111, "interrupt and reset pins after reset");
    check({ipce_n, irce_n, se1_n, se2_n, se3_n, roe_n, wrb_n}, 7'h7F,
          "chip enables after reset");

    // Address mapping over random segment setups
    for (int round = 0; round < 4; round++) begin
      for (int i = 0; i < 4; i++) begin
        rand_bits(8, r);
        io_write({8'h00, port_sr0 + 8'(i)}, r[7:0]);
      end
      rand_bits(1, r);
      io_write({8'h00, port_com}, {5'b00000, r[0], 2'b00});  // rams only
      for (int i = 0; i < 16; i++) begin
        rand_bits(17, r);
        mem_access(r[15:0], r[16]);
      end
    end

    // RTC restart and a run past a minute wrap
    io_write({8'h00, port_com}, 8'h10);
    io_write({8'h00, port_com}, 8'h00);
    c0 = cycle;                          // Edge where restim fell
    rand_bits(8, r);
    idle(rtc_cycles + int'(r[7:0]));
    for (int i = 0; i < 5; i++) begin
      io_read({8'h00, port_tim0 + 8'(i)}, d, c);
      t = exp_time((c - c0 - 1) / tb_div);  // State before the capture edge
      check(d, t[8*i +: 8], $sformatf("tim%0d", i));
    end

    // Timer interrupt, status and acknowledge
    io_write({8'h00, port_tmk}, 8'h01);
    io_write({8'h00, port_int}, 8'h03);
    wait_intb_low(3 * tb_div, "the first timer tick");
    io_read({8'h00, port_int}, d, c);
    check(d, 8'h02, "sta after timer event");
    int_ack();
    check(intb_n, 1'b1, "intb_n after acknowledge");
    wait_intb_low(3 * tb_div, "the next timer tick");
    io_write({8'h00, port_tack}, 8'h07);
    io_read({8'h00, port_tmk}, d, c);
    check(d, 8'h00, "tsta after TACK");
    io_write({8'h00, port_int}, 8'h00);
    int_ack();
    check(intb_n, 1'b1, "intb_n with interrupts off");
    check(nmib_n, 1'b1, "nmib_n after timer interrupts");

    // Keyboard rows
    for (int i = 0; i < 24; i++) begin
      rand_bits(64, r);
      kbmat = r;
      rand_bits(8, r);
      io_read({r[7:0], port_kbd}, d, c);
      check(d, exp_kbd(kbmat, r[7:0]), "keyboard read");
    end

    // HALT snooze until a timer interrupt
    hlt_n = 1'b0;
    idle(2);
    e0 = pm1_edges;
    idle(20);
    check(pm1_edges - e0, 0, "pm1 edges while halted");
    io_write({8'h00, port_int}, 8'h03);
    wait_intb_low(3 * tb_div, "the wake-up tick");
    e0 = pm1_edges;
    idle(4);
    check(pm1_edges - e0 >= 2, 1'b1, "pm1 running after wake-up");
    hlt_n = 1'b1;
    io_write({8'h00, port_int}, 8'h00);
    int_ack();

    // Keyboard wait with no key down
    io_write({8'h00, port_int}, 8'h80);
    kbmat = '0;
    io_read({8'hFF, port_kbd}, d, c);
    check(d, exp_kbd(kbmat, 8'hFF), "empty keyboard read");
    e0 = pm1_edges;
    idle(10);
    check(pm1_edges - e0, 0, "pm1 edges in keyboard snooze");
    kbmat = 64'h0000_0000_0000_0010;   // One key pressed
    io_read({8'hFF, port_kbd}, d, c);
    check(d, exp_kbd(kbmat, 8'hFF), "keyboard read with a key");
    e0 = pm1_edges;
    idle(4);
    check(pm1_edges - e0 >= 2, 1'b1, "pm1 running after a key");
    io_write({8'h00, port_int}, 8'h00);
    idle(4);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Longest wait is the RTC run
  initial begin
    #(wd_ns);
    $display("Watchdog expired, the tests did not complete in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- testbench/blink_checker.sv
module blink_checker (
  input logic       mck,
  input logic       rst_n,
  input logic [4:0] ce_n,     // ipce, irce, se1 to se3
  input logic       roe_n,
  input logic       wrb_n,
  input logic       intb_n,
  input logic       tim_hit   // Enabled timer event
);

  timeunit 1ns;
  timeprecision 100ps;

  // Internal chips and slots never overlap
  a_one_ce: assert property (@(posedge mck) disable iff (!rst_n) $onehot0(~ce_n))
    else $error("More than one chip enable is active");

  a_strobes: assert property (@(posedge mck) disable iff (!rst_n) (roe_n || wrb_n))
    else $error("Read and write strobes are active together");

  // intb_n only falls after an enabled timer event
  a_intb_cause: assert property (@(posedge mck) disable iff (!rst_n)
    $fell(intb_n) |-> $past(tim_hit))
    else $error("intb_n fell without an enabled timer event");

endmodule

// MMU side, interrupt pins tied inactive
bind blink_mmu blink_checker i_mmu_chk (
  .mck, .rst_n, .ce_n({ipce_n, irce_n, se1_n, se2_n, se3_n}), .roe_n, .wrb_n,
  .intb_n(1'b1), .tim_hit(1'b0)
);

// Interrupt side, memory pins tied inactive
bind blink_int_ctrl blink_checker i_ic_chk (
  .mck, .rst_n, .ce_n(5'h1F), .roe_n(1'b1), .wrb_n(1'b1), .intb_n, .tim_hit
);

//--- design/blink_top.sv
module blink_top import blink_pkg::*; #(
  parameter int tick_div = tick_div_default
) (
  input  logic        mck,
  input  logic        rst_n,
  input  logic [15:0] ca,
  input  logic [7:0]  cdi,
  input  logic        crd_n,
  input  logic        mrq_n,
  input  logic        ior_n,
  input  logic        cm1_n,
  input  logic        hlt_n,
  input  logic [63:0] kbmat,
  output logic [7:0]  cdo,
  output logic [21:0] ma,
  output logic        ipce_n,
  output logic        irce_n,
  output logic        se1_n,
  output logic        se2_n,
  output logic        se3_n,
  output logic        roe_n,
  output logic        wrb_n,
  output logic        intb_n,
  output logic        nmib_n,
  output logic        pm1,
  output logic        rout_n
);

  cpu_bus_t   bus;
  rtc_evt_t   evt;
  logic       restim;
  logic       rams;
  logic [2:0] tack;
  logic [2:0] tsta;
  logic [7:0] rtc_rd;
  logic       rtc_hit;
  logic [7:0] ic_rd;
  logic       ic_hit;
  logic [7:0] rd_sel;

  assign rout_n = rst_n;  // CPU reset follows ours

  // Peers never overlap on a port
  assign rd_sel = (rtc_hit ? rtc_rd : 8'h00) | (ic_hit ? ic_rd : 8'h00);

  blink_bus_if i_bus_if (
    .mck, .rst_n, .ca, .cdi, .mrq_n, .ior_n, .crd_n, .cm1_n, .hlt_n,
    .rd_sel, .bus, .cdo
  );

  blink_mmu i_mmu (
    .mck, .rst_n, .bus, .rams, .ma, .ipce_n, .irce_n,
    .se1_n, .se2_n, .se3_n, .roe_n, .wrb_n
  );

  blink_rtc #(.tick_div(tick_div)) i_rtc (
    .mck, .rst_n, .bus, .restim, .tack, .evt, .tsta,
    .rd_data(rtc_rd), .rd_hit(rtc_hit)
  );

  blink_int_ctrl i_int_ctrl (
    .mck, .rst_n, .bus, .evt, .tsta, .kbmat, .restim, .rams, .tack,
    .intb_n, .nmib_n, .pm1, .rd_data(ic_rd), .rd_hit(ic_hit)
  );

endmodule

//--- design/blink_int_ctrl.sv
module blink_int_ctrl import blink_pkg::*; (
  input  logic        mck,
  input  logic        rst_n,
  input  cpu_bus_t    bus,
  input  rtc_evt_t    evt,
  input  logic [2:0]  tsta,     // Latest timer status from the RTC
  input  logic [63:0] kbmat,    // 8 rows of 8 keys
  output logic        restim,
  output logic        rams,
  output logic [2:0]  tack,
  output logic        intb_n,
  output logic        nmib_n,
  output logic        pm1,      // Gated Z80 clock
  output logic [7:0]  rd_data,
  output logic        rd_hit
);

  logic [7:0] com;    // Common control
  logic [7:0] int1;   // Interrupt control
  logic [2:0] tmk;    // Timer mask
  logic [7:0] sta;    // Interrupt status
  logic       iak;    // Clear sta[1] on next read
  logic       intb;
  logic       pm1s;   // Z80 clock on
  logic       rd_q;   // io_rd last cycle
  logic       rd_start;
  logic       tim_hit;
  logic       kbd_rd;
  logic [7:0] kbd;    // Selected rows ORed
  logic       key_any;

  assign restim = com[4];
  assign rams   = com[2];

  // Pulse to the RTC on a TACK write
  assign tack = (bus.io_wr && bus.ca[7:0] == port_tack) ? bus.cdi[2:0] : 3'b000;

  // Row is selected by a high address line, A8 for row 0
  always_comb begin
    kbd = 8'h00;
    for (int r = 0; r < 8; r++) begin
      if (bus.ca[8+r]) begin
        kbd = kbd | kbmat[8*r +: 8];
      end
    end
  end

  assign key_any  = |kbd;
  assign rd_start = bus.io_rd & ~rd_q;  // First cycle of a read
  assign kbd_rd   = bus.io_rd && bus.ca[7:0] == port_kbd;

  // Timer events pass only with both enables and a masked status bit
  assign tim_hit = evt.tick & ~evt.restim & int1[int1_gint] & int1[int1_time] &
                   |(tsta & tmk);

  always_ff @(posedge mck or negedge rst_n) begin
    if (!rst_n) begin
      com  <= 8'h00;
      int1 <= 8'h00;
      tmk  <= 3'b000;
      sta  <= 8'h00;
      iak  <= 1'b0;
      intb <= 1'b0;
      pm1s <= 1'b1;
      rd_q <= 1'b0;
    end else begin
      rd_q <= bus.io_rd;
      if (bus.io_wr) begin
        case (bus.ca[7:0])
          port_com: com  <= bus.cdi;
          port_int: int1 <= bus.cdi;
          port_tmk: tmk  <= bus.cdi[2:0];
          port_ack: sta  <= sta & ~(bus.cdi & sta_ack_mask);
          default: ;
        endcase
      end
      // Auto acknowledge of the timer flag
      if (rd_start) begin
        if (iak) begin
          sta[1] <= 1'b0;
          iak    <= 1'b0;
        end else if (bus.ca[7:0] == port_int) begin
          iak <= 1'b1;
        end
      end
      if (kbd_rd && key_any && int1[int1_key]) begin
        sta[2] <= 1'b1;                  // Key seen
      end
      if (tim_hit) begin
        sta[1] <= 1'b1;
      end
      // Acknowledge beats a new event
      if (bus.int_ack) begin
        intb             <= 1'b0;
        int1[int1_kwait] <= 1'b0;
      end else if (tim_hit) begin
        intb <= 1'b1;
      end
      // Clock switch
      if (intb) begin
        pm1s <= 1'b1;                    // Interrupt wakes the CPU
      end else if (bus.halt) begin
        pm1s <= 1'b0;                    // Snooze
      end else if (kbd_rd) begin
        pm1s <= ~int1[int1_kwait] | key_any;
      end
    end
  end

  always_comb begin
    rd_hit  = 1'b1;
    rd_data = 8'h00;
    case (bus.ca[7:0])
      port_int: rd_data = sta;
      port_kbd: rd_data = kbd;
      default:  rd_hit  = 1'b0;
    endcase
  end

  assign intb_n = ~intb;
  assign nmib_n = 1'b1;       // No NMI source here
  assign pm1    = mck & pm1s;

endmodule

//--- design/blink_rtc.sv
module blink_rtc import blink_pkg::*; #(
  parameter int tick_div = tick_div_default  // mck cycles per 5 ms
) (
  input  logic       mck,
  input  logic       rst_n,
  input  cpu_bus_t   bus,
  input  logic       restim,   // Hold counters at zero
  input  logic [2:0] tack,     // tsta bits to clear
  output rtc_evt_t   evt,
  output logic [2:0] tsta,     // Minute, second, tick
  output logic [7:0] rd_data,
  output logic       rd_hit
);

  localparam int div_w = (tick_div > 1) ? $clog2(tick_div) : 1;

  logic [div_w-1:0] div_cnt;
  logic [7:0]       tim0;     // 0-199
  logic [5:0]       tim1;     // 0-59
  logic [20:0]      timm;     // Free running minutes
  logic             tick_now;
  logic             sec_now;
  logic             min_now;
  logic             tick_q;
  logic             sec_q;
  logic             min_q;

  // Divider terminal count, none while in reset
  assign tick_now = ~restim && div_cnt == div_w'(tick_div - 1);
  assign sec_now  = tick_now && tim0 == 8'(ticks_per_sec - 1);
  assign min_now  = sec_now && tim1 == 6'(secs_per_min - 1);

  always_ff @(posedge mck or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      tim0    <= 8'h00;
      tim1    <= 6'h00;
      timm    <= 21'h0;
      tsta    <= 3'b000;
    end else if (restim) begin
      // Set then clear restim to restart from zero
      div_cnt <= '0;
      tim0    <= 8'h00;
      tim1    <= 6'h00;
      timm    <= 21'h0;
      tsta    <= 3'b000;
    end else begin
      div_cnt <= tick_now ? '0 : div_cnt + 1'b1;
      tsta    <= tsta & ~tack;  // TACK clear
      if (tick_now) begin
        if (!sec_now) begin
          tim0 <= tim0 + 8'd1;
          tsta <= 3'b001;
        end else if (!min_now) begin
          tim0 <= 8'h00;
          tim1 <= tim1 + 6'd1;
          tsta <= 3'b011;
        end else begin
          tim0 <= 8'h00;
          tim1 <= 6'h00;
          timm <= timm + 21'd1;
          tsta <= 3'b111;
        end
      end
    end
  end

  // Pulses line up with the new counter values
  always_ff @(posedge mck or negedge rst_n) begin
    if (!rst_n) begin
      tick_q <= 1'b0;
      sec_q  <= 1'b0;
      min_q  <= 1'b0;
    end else begin
      tick_q <= tick_now;
      sec_q  <= sec_now;
      min_q  <= min_now;
    end
  end

  assign evt = '{tick: tick_q, sec_wrap: sec_q, min_wrap: min_q, restim: restim};

  // Timer read ports
  always_comb begin
    rd_hit  = 1'b1;
    rd_data = 8'h00;
    case (bus.ca[7:0])
      port_tim0: rd_data = tim0;
      port_tim1: rd_data = {2'b00, tim1};
      port_tim2: rd_data = timm[7:0];
      port_tim3: rd_data = timm[15:8];
      port_tim4: rd_data = {3'b000, timm[20:16]};
      port_tmk:  rd_data = {5'b00000, tsta};  // Status reads back on B5
      default:   rd_hit  = 1'b0;
    endcase
  end

endmodule

//--- design/blink_mmu.sv
module blink_mmu import blink_pkg::*; (
  input  logic        mck,
  input  logic        rst_n,
  input  cpu_bus_t    bus,
  input  logic        rams,    // com[2]
  output logic [21:0] ma,
  output logic        ipce_n,  // Internal PROM
  output logic        irce_n,  // Internal RAM
  output logic        se1_n,
  output logic        se2_n,
  output logic        se3_n,
  output logic        roe_n,
  output logic        wrb_n
);

  logic [7:0] sr [4];  // Segment registers
  seg_map_t   seg;
  logic [7:0] low_bank; // Bank behind 0000-1FFF
  logic [1:0] slot;     // ma[21:20]

  // Segment registers, write only
  always_ff @(posedge mck or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 4; i++) begin
        sr[i] <= 8'h00;
      end
    end else if (bus.io_wr) begin
      case (bus.ca[7:0])
        port_sr0: sr[0] <= bus.cdi;
        port_sr1: sr[1] <= bus.cdi;
        port_sr2: sr[2] <= bus.cdi;
        port_sr3: sr[3] <= bus.cdi;
        default: ;
      endcase
    end
  end

  assign seg = '{sr0: sr[0], sr1: sr[1], sr2: sr[2], sr3: sr[3], rams: rams};

  assign low_bank = seg.rams ? rams_bank : 8'h00; // RAMS swaps ROM for RAM

  // 16K quarters, lowest one split in 8K halves
  always_comb begin
    case (bus.ca[15:14])
      2'b11: ma = {seg.sr3, bus.ca[13:0]};
      2'b10: ma = {seg.sr2, bus.ca[13:0]};
      2'b01: ma = {seg.sr1, bus.ca[13:0]};
      default: begin
        if (bus.ca[13]) begin
          ma = {seg.sr0, 1'b1, bus.ca[12:0]};  // 2000-3FFF
        end else begin
          ma = {low_bank, 1'b0, bus.ca[12:0]}; // 0000-1FFF
        end
      end
    endcase
  end

  assign slot = ma[21:20];

  // Slot 0 is split between PROM and RAM by ma[19]
  assign ipce_n = ~(bus.mreq && ma[21:19] == prom_bank_hi);
  assign irce_n = ~(bus.mreq && ma[21:19] == ram_bank_hi);
  assign se1_n  = ~(bus.mreq && slot == 2'd1);
  assign se2_n  = ~(bus.mreq && slot == 2'd2);
  assign se3_n  = ~(bus.mreq && slot == 2'd3);

  // Read strobe vs write strobe
  assign roe_n = ~(bus.mreq & bus.rd);
  assign wrb_n = ~(bus.mreq & ~bus.rd);

endmodule

//--- design/blink_bus_if.sv
module blink_bus_if import blink_pkg::*; (
  input  logic        mck,
  input  logic        rst_n,
  input  logic [15:0] ca,
  input  logic [7:0]  cdi,
  input  logic        mrq_n,
  input  logic        ior_n,
  input  logic        crd_n,
  input  logic        cm1_n,
  input  logic        hlt_n,
  input  logic [7:0]  rd_sel,  // ORed peer read bytes
  output cpu_bus_t    bus,
  output logic [7:0]  cdo
);

  logic       io_cyc;  // ior_n low, not an acknowledge
  logic [7:0] r_cdo;   // Latched read byte

  // M1 with ior_n is the interrupt acknowledge, never a register access
  assign io_cyc = ~ior_n & cm1_n;

  // Only place where the pins get decoded
  assign bus = '{
    ca:      ca,
    cdi:     cdi,
    mreq:    ~mrq_n,
    rd:      ~crd_n,
    io_wr:   io_cyc & crd_n,   // crd_n high is a write
    io_rd:   io_cyc & ~crd_n,  // crd_n low is a read
    int_ack: ~ior_n & ~cm1_n,
    halt:    ~hlt_n
  };

  // Sampled on every edge of the read, last one wins
  always_ff @(posedge mck or negedge rst_n) begin
    if (!rst_n) begin
      r_cdo <= 8'h00;
    end else if (bus.io_rd) begin
      r_cdo <= rd_sel;
    end
  end

  // Bus passes write data through outside of I/O cycles
  assign cdo = ior_n ? cdi : r_cdo;

endmodule

//--- design/blink_pkg.sv
package blink_pkg;

  // Decoded CPU bus, all flags active high
  typedef struct packed {
    logic [15:0] ca;       // Z80 address
    logic [7:0]  cdi;      // Z80 write data
    logic        mreq;     // Memory cycle
    logic        rd;       // crd_n low
    logic        io_wr;    // I/O write, crd_n high
    logic        io_rd;    // I/O read, crd_n low
    logic        int_ack;  // ior_n with cm1_n
    logic        halt;     // Z80 in HALT
  } cpu_bus_t;

  // Bank switching state
  typedef struct packed {
    logic [7:0] sr0;  // 2000-3FFF, upper 8K of bank
    logic [7:0] sr1;  // 4000-7FFF
    logic [7:0] sr2;  // 8000-BFFF
    logic [7:0] sr3;  // C000-FFFF
    logic       rams; // com[2], RAM at 0000
  } seg_map_t;

  // RTC events, one mck cycle wide
  typedef struct packed {
    logic tick;      // 5 ms
    logic sec_wrap;  // tim0 rolled over
    logic min_wrap;  // tim1 rolled over
    logic restim;    // Timer held in reset
  } rtc_evt_t;

  // I/O ports, control group
  localparam logic [7:0] port_com  = 8'hB0; // Common control, W
  localparam logic [7:0] port_int  = 8'hB1; // int1 W, sta R
  localparam logic [7:0] port_kbd  = 8'hB2; // Keyboard, R
  localparam logic [7:0] port_tack = 8'hB4; // Timer ack, W
  localparam logic [7:0] port_tmk  = 8'hB5; // tmk W, tsta R
  localparam logic [7:0] port_ack  = 8'hB6; // Int ack, W

  // Segment registers share D0-D3 with timer reads
  localparam logic [7:0] port_sr0  = 8'hD0;
  localparam logic [7:0] port_sr1  = 8'hD1;
  localparam logic [7:0] port_sr2  = 8'hD2;
  localparam logic [7:0] port_sr3  = 8'hD3;

  localparam logic [7:0] port_tim0 = 8'hD0; // 5 ms ticks
  localparam logic [7:0] port_tim1 = 8'hD1; // Seconds
  localparam logic [7:0] port_tim2 = 8'hD2; // Minutes, low byte
  localparam logic [7:0] port_tim3 = 8'hD3; // 256 minutes
  localparam logic [7:0] port_tim4 = 8'hD4; // 64K minutes

  // 9.8304 MHz / 49152 = 200 Hz
  localparam int tick_div_default = 49152;
  localparam int ticks_per_sec    = 200;
  localparam int secs_per_min     = 60;

  // Physical memory
  localparam logic [7:0] rams_bank    = 8'h20;  // First RAM bank
  localparam logic [2:0] prom_bank_hi = 3'b000; // ma[21:19], internal ROM
  localparam logic [2:0] ram_bank_hi  = 3'b001; // ma[21:19], internal RAM

  // int1 bit positions
  localparam int int1_gint  = 0; // Global enable
  localparam int int1_time  = 1; // Timer enable
  localparam int int1_key   = 2; // Key status enable
  localparam int int1_kwait = 7; // Snooze on empty keyboard read

  // sta bits that a B6 write may clear
  localparam logic [7:0] sta_ack_mask = 8'h6E;

endpackage
